//--- fp_fmt_pkg.sv
// ------------------------------
// Floating-point format definitions for the 32-bit two-lane slice
// Only FP32 and FP16 are supported, two FP16 lanes fit in one slice
// ------------------------------

package fp_fmt_pkg;

  // ------------------------------
  // Slice geometry
  // ------------------------------
  localparam int unsigned SLICE_WIDTH = 32;
  localparam int unsigned NUM_LANES   = 2;

  // ------------------------------
  // Format field widths
  // ------------------------------
  localparam int unsigned FP32_WIDTH    = 32;
  localparam int unsigned FP32_EXP_BITS = 8;
  localparam int unsigned FP32_MAN_BITS = 23;

  localparam int unsigned FP16_WIDTH    = 16;
  localparam int unsigned FP16_EXP_BITS = 5;
  localparam int unsigned FP16_MAN_BITS = 10;

  // Canonical quiet NaNs, positive sign and only the quiet bit set
  localparam logic [FP32_WIDTH-1:0] FP32_QNAN = 32'h7FC0_0000;
  localparam logic [FP16_WIDTH-1:0] FP16_QNAN = 16'h7E00;

  // Active format of an operation
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_fmt_e;

  // IEEE 754 exception flags
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

endpackage

//--- simd_op_pkg.sv
// ------------------------------
// Operation, handshake payload and pipeline definitions
// Depends on fp_fmt_pkg, which must be compiled first
// ------------------------------

package simd_op_pkg;

  // Non-computational operations
  typedef enum logic [2:0] {
    MIN   = 3'd0,
    MAX   = 3'd1,
    SGNJ  = 3'd2,
    SGNJN = 3'd3,
    SGNJX = 3'd4
  } op_e;

  localparam int unsigned NUM_PIPE_REGS = 2;
  localparam int unsigned TAG_WIDTH     = 4;

  // Request as seen at the slice input
  typedef struct packed {
    logic [fp_fmt_pkg::SLICE_WIDTH-1:0] a;
    logic [fp_fmt_pkg::SLICE_WIDTH-1:0] b;
    op_e                                op;
    fp_fmt_pkg::fp_fmt_e                fmt;
    logic                               vectorial;
    logic [TAG_WIDTH-1:0]               tag;
  } simd_req_t;

  // Response as seen at the slice output
  typedef struct packed {
    logic [fp_fmt_pkg::SLICE_WIDTH-1:0] result;
    fp_fmt_pkg::status_t                status;
    logic [TAG_WIDTH-1:0]               tag;
  } simd_rsp_t;

  // Format info travelling next to the lane results
  typedef struct packed {
    fp_fmt_pkg::fp_fmt_e fmt;
    logic                vec;
  } lane_aux_t;

  // What the pipeline registers hold per stage
  typedef struct packed {
    logic [fp_fmt_pkg::NUM_LANES-1:0][fp_fmt_pkg::FP16_WIDTH-1:0] lane_res;
    logic [fp_fmt_pkg::FP16_WIDTH-1:0]                            lane0_hi;
    fp_fmt_pkg::status_t [fp_fmt_pkg::NUM_LANES-1:0]              lane_status;
    lane_aux_t                                                    aux;
    logic [TAG_WIDTH-1:0]                                         tag;
  } pipe_payload_t;

endpackage

//--- fp_lane_op.sv
// ------------------------------
// Min/max and sign injection for one lane, purely combinational
// A 16-bit instance always works in FP16, fmt_i only matters at 32 bits
// ------------------------------
`timescale 1ns/1ps

module fp_lane_op #(
  parameter int unsigned LANE_WIDTH = 32
) (
  input  logic [LANE_WIDTH-1:0] a_i,
  input  logic [LANE_WIDTH-1:0] b_i,
  input  simd_op_pkg::op_e      op_i,
  input  fp_fmt_pkg::fp_fmt_e   fmt_i,
  output logic [LANE_WIDTH-1:0] result_o,
  output fp_fmt_pkg::status_t   status_o
);

  localparam int unsigned W32 = fp_fmt_pkg::FP32_WIDTH;
  localparam int unsigned W16 = fp_fmt_pkg::FP16_WIDTH;
  localparam bit HAS_FP32 = (LANE_WIDTH >= W32);

  typedef struct packed {
    logic           sign;
    logic           nan;
    logic           snan;
    logic           zero;
    logic [W32-2:0] mag;
  } class_t;

  // Classify a value in the wide or narrow format
  function automatic class_t classify(input logic [W32-1:0] v, input logic wide);
    class_t c;
    logic   exp_ones;
    logic   man_nz;
    logic   quiet;
    if (wide) begin
      exp_ones = &v[W32-2 -: fp_fmt_pkg::FP32_EXP_BITS];
      man_nz   = |v[fp_fmt_pkg::FP32_MAN_BITS-1:0];
      quiet    = v[fp_fmt_pkg::FP32_MAN_BITS-1];
      c.sign   = v[W32-1];
      c.mag    = v[W32-2:0];
    end else begin
      exp_ones = &v[W16-2 -: fp_fmt_pkg::FP16_EXP_BITS];
      man_nz   = |v[fp_fmt_pkg::FP16_MAN_BITS-1:0];
      quiet    = v[fp_fmt_pkg::FP16_MAN_BITS-1];
      c.sign   = v[W16-1];
      c.mag    = (W32-1)'(v[W16-2:0]);
    end
    c.zero = ~|c.mag;
    c.nan  = exp_ones & man_nz;
    c.snan = c.nan & ~quiet;
    return c;
  endfunction

  logic           wide;
  logic [W32-1:0] a_ext, b_ext, qnan, res;
  class_t         ca, cb;
  logic           a_lt_b;
  logic           new_sign;

  assign wide  = HAS_FP32 && (fmt_i == fp_fmt_pkg::FP32);
  assign a_ext = W32'(a_i);
  assign b_ext = W32'(b_i);
  assign ca    = classify(a_ext, wide);
  assign cb    = classify(b_ext, wide);
  assign qnan  = wide ? fp_fmt_pkg::FP32_QNAN : W32'(fp_fmt_pkg::FP16_QNAN);

  // Sign-magnitude ordering, -0 sorts below +0
  always_comb begin
    if (ca.zero && cb.zero) begin
      a_lt_b = ca.sign & ~cb.sign;
    end else if (ca.sign != cb.sign) begin
      a_lt_b = ca.sign;
    end else if (!ca.sign) begin
      a_lt_b = ca.mag < cb.mag;
    end else begin
      a_lt_b = ca.mag > cb.mag;
    end
  end

  always_comb begin
    res      = qnan;
    new_sign = cb.sign;
    status_o = '0;
    case (op_i)
      simd_op_pkg::MIN, simd_op_pkg::MAX: begin
        status_o.nv = ca.snan | cb.snan;
        if (ca.nan && cb.nan) res = qnan;
        else if (ca.nan) res = b_ext;
        else if (cb.nan) res = a_ext;
        else if ((op_i == simd_op_pkg::MIN) == a_lt_b) res = a_ext;
        else res = b_ext;
      end
      simd_op_pkg::SGNJ, simd_op_pkg::SGNJN, simd_op_pkg::SGNJX: begin
        if (op_i == simd_op_pkg::SGNJN) new_sign = ~cb.sign;
        else if (op_i == simd_op_pkg::SGNJX) new_sign = ca.sign ^ cb.sign;
        // Magnitude of a is kept untouched
        if (wide) res = {new_sign, ca.mag};
        else res = {{W16{1'b0}}, new_sign, ca.mag[W16-2:0]};
      end
      default: res = qnan;
    endcase
  end

  assign result_o = res[LANE_WIDTH-1:0];

  always_comb begin
    if (!$isunknown({a_i, b_i, op_i, fmt_i})) begin
      assert (!$isunknown(result_o))
        else $error("fp_lane_op: unknown result from known inputs");
    end
  end

endmodule

//--- lane_pipe.sv
// ------------------------------
// Bubble-popping valid/ready pipeline of NUM_PIPE_REGS stages
// Ready is combinational from out_ready_i back to in_ready_o
// ------------------------------
`timescale 1ns/1ps

module lane_pipe (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  simd_op_pkg::pipe_payload_t payload_i,
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output simd_op_pkg::pipe_payload_t payload_o,
  output logic                       busy_o
);

  localparam int unsigned DEPTH = simd_op_pkg::NUM_PIPE_REGS;

  // Index i is the view after i register stages
  logic       [DEPTH:0]                   stage_valid;
  logic       [DEPTH:0]                   stage_ready;
  simd_op_pkg::pipe_payload_t [DEPTH:0]   stage_data;

  logic       [DEPTH-1:0]                 valid_q;
  simd_op_pkg::pipe_payload_t [DEPTH-1:0] data_q;

  assign stage_valid[0] = in_valid_i;
  assign stage_data[0]  = payload_i;

  // Move on if the next stage takes data or only holds a bubble
  always_comb begin
    stage_ready[DEPTH] = out_ready_i;
    for (int i = int'(DEPTH) - 1; i >= 0; i--) begin
      stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];
    end
  end

  // ------------------------------
  // Register stages
  // ------------------------------
  for (genvar i = 0; i < DEPTH; i++) begin : gen_stage
    logic advance;

    assign advance = stage_ready[i] & stage_valid[i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q[i] <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q[i] <= stage_valid[i];
      end
    end

    // Payload only loads when a valid item moves in
    always_ff @(posedge clk_i) begin
      if (advance) begin
        data_q[i] <= stage_data[i];
      end
    end

    assign stage_valid[i+1] = valid_q[i];
    assign stage_data[i+1]  = data_q[i];
  end

  assign in_ready_o  = stage_ready[0];
  assign out_valid_o = stage_valid[DEPTH];
  assign payload_o   = stage_data[DEPTH];
  assign busy_o      = |valid_q;

  // ------------------------------
  // Checks
  // ------------------------------
  a_hold_under_stall: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(payload_o)
  ) else $error("lane_pipe: output changed while stalled");

  a_valid_known: assert property (
    @(posedge clk_i) rst_n_i |-> !$isunknown(out_valid_o)
  ) else $error("lane_pipe: out_valid_o is unknown");

endmodule

//--- result_pack.sv
// ------------------------------
// Rebuilds the 32-bit result and merges the lane status
// Scalar FP16 results are NaN-boxed in the upper half
// ------------------------------
`timescale 1ns/1ps

module result_pack (
  input  simd_op_pkg::pipe_payload_t payload_i,
  output simd_op_pkg::simd_rsp_t     rsp_o
);

  localparam int unsigned W16 = fp_fmt_pkg::FP16_WIDTH;

  logic [fp_fmt_pkg::NUM_LANES-1:0] lane_used;
  logic                             is_fp32;
  logic                             is_vec;

  assign is_fp32 = (payload_i.aux.fmt == fp_fmt_pkg::FP32);
  assign is_vec  = payload_i.aux.vec;

  // Lane 0 always counts, upper lanes only for vector ops
  always_comb begin
    for (int i = 0; i < int'(fp_fmt_pkg::NUM_LANES); i++) begin
      lane_used[i] = (i == 0) || is_vec;
    end
  end

  // ------------------------------
  // Result assembly
  // ------------------------------
  always_comb begin
    if (is_fp32) begin
      rsp_o.result = {payload_i.lane0_hi, payload_i.lane_res[0]};
    end else if (is_vec) begin
      rsp_o.result = {payload_i.lane_res[1], payload_i.lane_res[0]};
    end else begin
      // NaN-box the narrow scalar
      rsp_o.result = {{W16{1'b1}}, payload_i.lane_res[0]};
    end
  end

  // Collapse the status of the active lanes
  always_comb begin
    fp_fmt_pkg::status_t merged;
    merged = '0;
    for (int i = 0; i < int'(fp_fmt_pkg::NUM_LANES); i++) begin
      if (lane_used[i]) begin
        merged = merged | payload_i.lane_status[i];
      end
    end
    rsp_o.status = merged;
  end

  assign rsp_o.tag = payload_i.tag;

endmodule

//--- simd_slice_top.sv
// ------------------------------
// Two-lane FP32/FP16 non-computational slice
// Vectorial FP32 requests run as scalar, latency is NUM_PIPE_REGS
// ------------------------------
`timescale 1ns/1ps

module simd_slice_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  simd_op_pkg::simd_req_t req_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output simd_op_pkg::simd_rsp_t rsp_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic                   busy_o
);

  localparam int unsigned W32 = fp_fmt_pkg::FP32_WIDTH;
  localparam int unsigned W16 = fp_fmt_pkg::FP16_WIDTH;
  localparam int unsigned SW  = fp_fmt_pkg::SLICE_WIDTH;

  logic                       vec_eff;
  logic                       narrow_scalar;
  logic [W32-1:0]             lane0_a, lane0_b, lane0_res;
  logic [W16-1:0]             lane1_a, lane1_b, lane1_res;
  fp_fmt_pkg::status_t        lane0_status, lane1_status;
  simd_op_pkg::pipe_payload_t pipe_in, pipe_out;

  // ------------------------------
  // Operand preparation
  // ------------------------------
  assign vec_eff       = req_i.vectorial && (req_i.fmt == fp_fmt_pkg::FP16);
  assign narrow_scalar = (req_i.fmt == fp_fmt_pkg::FP16) && !vec_eff;

  // Unboxed narrow scalars are treated as canonical NaN
  always_comb begin
    lane0_a = req_i.a;
    lane0_b = req_i.b;
    if (narrow_scalar && !(&req_i.a[SW-1:W16])) lane0_a = {{W16{1'b1}}, fp_fmt_pkg::FP16_QNAN};
    if (narrow_scalar && !(&req_i.b[SW-1:W16])) lane0_b = {{W16{1'b1}}, fp_fmt_pkg::FP16_QNAN};
  end

  assign lane1_a = req_i.a[SW-1 -: W16];
  assign lane1_b = req_i.b[SW-1 -: W16];

  fp_lane_op #(.LANE_WIDTH(W32)) u_lane0 (
    .a_i      (lane0_a),
    .b_i      (lane0_b),
    .op_i     (req_i.op),
    .fmt_i    (req_i.fmt),
    .result_o (lane0_res),
    .status_o (lane0_status)
  );

  fp_lane_op #(.LANE_WIDTH(W16)) u_lane1 (
    .a_i      (lane1_a),
    .b_i      (lane1_b),
    .op_i     (req_i.op),
    .fmt_i    (req_i.fmt),
    .result_o (lane1_res),
    .status_o (lane1_status)
  );

  // ------------------------------
  // Payload and pipeline
  // ------------------------------
  assign pipe_in.lane_res[0]    = lane0_res[W16-1:0];
  assign pipe_in.lane_res[1]    = lane1_res;
  assign pipe_in.lane0_hi       = lane0_res[W32-1:W16];
  assign pipe_in.lane_status[0] = lane0_status;
  assign pipe_in.lane_status[1] = lane1_status;
  assign pipe_in.aux.fmt        = req_i.fmt;
  assign pipe_in.aux.vec        = vec_eff;
  assign pipe_in.tag            = req_i.tag;

  lane_pipe u_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .payload_i   (pipe_in),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .payload_o   (pipe_out),
    .busy_o      (busy_o)
  );

  result_pack u_pack (
    .payload_i (pipe_out),
    .rsp_o     (rsp_o)
  );

endmodule

//--- tb_clk_gen.sv
// ------------------------------
// Testbench clock and active-low reset
// Reset is released on a falling edge after RESET_CYCLES cycles
// ------------------------------
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- tb_ref_model.svh
// ------------------------------
// Reference model of the slice built from the IEEE min/max and sign rules
// Meant to be included inside the testbench module
// ------------------------------
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// One lane in FP32 (wide) or FP16, returns {nv, result}
function automatic logic [32:0] ref_lane(input logic [31:0] a, input logic [31:0] b,
                                         input simd_op_pkg::op_e op, input bit wide);
  int          w;
  logic [31:0] mag_mask;
  logic [31:0] man_mask;
  logic [31:0] quiet;
  logic [31:0] ma;
  logic [31:0] mb;
  logic [31:0] res;
  logic [32:0] key_a;
  logic [32:0] key_b;
  logic        nan_a;
  logic        nan_b;
  logic        nv;
  logic        sign;
  w        = wide ? 32 : 16;
  mag_mask = (32'h1 << (w - 1)) - 32'h1;
  man_mask = (32'h1 << (wide ? 23 : 10)) - 32'h1;
  quiet    = (man_mask + 32'h1) >> 1;
  ma       = a & mag_mask;
  mb       = b & mag_mask;
  nan_a    = ((ma & ~man_mask) == (mag_mask & ~man_mask)) && ((ma & man_mask) != 0);
  nan_b    = ((mb & ~man_mask) == (mag_mask & ~man_mask)) && ((mb & man_mask) != 0);
  // Total order key, negative values invert the magnitude so -0 < +0
  key_a    = a[w-1] ? {1'b0, ~ma} : {1'b1, ma};
  key_b    = b[w-1] ? {1'b0, ~mb} : {1'b1, mb};
  nv       = 1'b0;
  sign     = b[w-1];
  // Canonical NaN has all exponent bits and the quiet bit set
  res      = (mag_mask & ~man_mask) | quiet;
  case (op)
    simd_op_pkg::MIN, simd_op_pkg::MAX: begin
      nv = (nan_a && ((ma & quiet) == 0)) || (nan_b && ((mb & quiet) == 0));
      if (nan_a && !nan_b) res = b;
      else if (nan_b && !nan_a) res = a;
      else if (!nan_a) res = ((op == simd_op_pkg::MIN) == (key_a < key_b)) ? a : b;
    end
    simd_op_pkg::SGNJ, simd_op_pkg::SGNJN, simd_op_pkg::SGNJX: begin
      if (op == simd_op_pkg::SGNJN) sign = ~b[w-1];
      if (op == simd_op_pkg::SGNJX) sign = a[w-1] ^ b[w-1];
      res = ({31'h0, sign} << (w - 1)) | ma;
    end
    default: ;
  endcase
  return {nv, res & (mag_mask | (32'h1 << (w - 1)))};
endfunction

// Expected response of the whole slice for one request
function automatic simd_op_pkg::simd_rsp_t ref_response(input simd_op_pkg::simd_req_t r);
  simd_op_pkg::simd_rsp_t out;
  logic [32:0]            lo;
  logic [32:0]            hi;
  logic [31:0]            a;
  logic [31:0]            b;
  out     = '0;
  out.tag = r.tag;
  if (r.fmt == fp_fmt_pkg::FP32) begin
    lo            = ref_lane(r.a, r.b, r.op, 1'b1);
    out.result    = lo[31:0];
    out.status.nv = lo[32];
  end else if (r.vectorial) begin
    // Two independent FP16 lanes
    lo            = ref_lane({16'h0, r.a[15:0]}, {16'h0, r.b[15:0]}, r.op, 1'b0);
    hi            = ref_lane({16'h0, r.a[31:16]}, {16'h0, r.b[31:16]}, r.op, 1'b0);
    out.result    = {hi[15:0], lo[15:0]};
    out.status.nv = lo[32] | hi[32];
  end else begin
    // Scalar FP16 operand without a NaN box reads as quiet NaN
    a             = (r.a[31:16] == 16'hFFFF) ? r.a : {16'h0, fp_fmt_pkg::FP16_QNAN};
    b             = (r.b[31:16] == 16'hFFFF) ? r.b : {16'h0, fp_fmt_pkg::FP16_QNAN};
    lo            = ref_lane(a, b, r.op, 1'b0);
    out.result    = {16'hFFFF, lo[15:0]};
    out.status.nv = lo[32];
  end
  return out;
endfunction

`endif

//--- simd_slice_tb.sv
// ------------------------------
// Random testbench for the two-lane slice, seed 55
// Responses are checked in order against the included reference model
// ------------------------------
`timescale 1ns/1ps

module simd_slice_tb;

  localparam int NUM_TXN        = 500;
  localparam int TIMEOUT_CYCLES = 20 * NUM_TXN + 100;

  logic                   clk;
  logic                   rst_n;
  simd_op_pkg::simd_req_t req;
  logic                   in_valid;
  logic                   in_ready;
  simd_op_pkg::simd_rsp_t rsp;
  logic                   out_valid;
  logic                   out_ready;
  logic                   busy;

  int                     seed;
  int                     cycle;
  logic                   took_req;
  logic                   fixed_latency;
  logic [3:0]             next_tag;
  string                  phase_name;
  simd_op_pkg::simd_rsp_t exp_q[$];
  int                     acc_q[$];

  tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(3)) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  simd_slice_top uut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .rsp_o       (rsp),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .busy_o      (busy)
  );

  `include "tb_ref_model.svh"

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "Value mismatch in %s", name);
    end
  endtask

  function automatic int rand_below(input int n);
    return int'(unsigned'($random(seed)) % unsigned'(n));
  endfunction

  // ------------------------------
  // Stimulus
  // ------------------------------
  // Biased picks favour signed zeros, infinities and both NaN kinds
  function automatic logic [31:0] pick_value(input bit wide, input bit biased);
    logic [31:0] r;
    logic [31:0] sign;
    logic [31:0] inf;
    logic [31:0] qbit;
    logic [31:0] low;
    r    = $random(seed);
    sign = r & (wide ? 32'h8000_0000 : 32'h0000_8000);
    inf  = wide ? 32'h7F80_0000 : 32'h0000_7C00;
    qbit = wide ? 32'h0040_0000 : 32'h0000_0200;
    low  = r & (qbit - 32'h1);
    if (!biased) return wide ? r : (r & 32'h0000_FFFF);
    case (rand_below(8))
      0: return sign;
      1: return sign | inf;
      2: return sign | inf | qbit | low;
      3: return sign | inf | low | 32'h1;
      default: return wide ? r : (r & 32'h0000_FFFF);
    endcase
  endfunction

  function automatic logic [31:0] pick_operand(input int m, input bit biased);
    logic [31:0] hi;
    logic [31:0] lo;
    if (m == 0) return pick_value(1'b1, biased);
    lo = pick_value(1'b0, biased);
    hi = pick_value(1'b0, biased);
    // One scalar FP16 operand in four stays unboxed
    if (m == 2 && rand_below(4) != 0) hi = 32'h0000_FFFF;
    return {hi[15:0], lo[15:0]};
  endfunction

  // Mode 0 FP32, 1 vector FP16, 2 scalar FP16, 3 any of them
  function automatic simd_op_pkg::simd_req_t make_req(input int mode, input bit biased);
    simd_op_pkg::simd_req_t r;
    int                     m;
    m           = (mode == 3) ? rand_below(3) : mode;
    r.op        = simd_op_pkg::op_e'(3'(rand_below(5)));
    r.fmt       = (m == 0) ? fp_fmt_pkg::FP32 : fp_fmt_pkg::FP16;
    r.vectorial = (m == 1) || (m == 0 && rand_below(2) == 1);
    r.a         = pick_operand(m, biased);
    r.b         = pick_operand(m, biased);
    r.tag       = next_tag;
    next_tag    = next_tag + 4'd1;
    return r;
  endfunction

  task automatic run_phase(input string name, input int mode, input int count,
                           input int stall_pct, input bit biased);
    int issued;
    issued        = 0;
    phase_name    = name;
    fixed_latency = (stall_pct == 0);
    forever begin
      @(negedge clk);
      out_ready = (stall_pct == 0) || (rand_below(100) >= stall_pct);
      // Hold the request until it transfers
      if (!in_valid || took_req) begin
        if (issued == count) break;
        if (rand_below(4) == 0) begin
          in_valid = 1'b0;
        end else begin
          req      = make_req(mode, biased);
          in_valid = 1'b1;
          issued++;
        end
      end
    end
    in_valid  = 1'b0;
    out_ready = 1'b1;
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
    check_value({name, " busy after drain"}, 32'h0, 32'(busy));
  endtask

  // ------------------------------
  // Monitor and scoreboard
  // ------------------------------
  task automatic check_response();
    simd_op_pkg::simd_rsp_t expected;
    int                     acc_cycle;
    if (exp_q.size() == 0) begin
      $display("Simulation FAILED");
      $fatal(1, "A response arrived with no request outstanding");
    end else begin
      expected  = exp_q.pop_front();
      acc_cycle = acc_q.pop_front();
      check_value({phase_name, " tag"}, 32'(expected.tag), 32'(rsp.tag));
      check_value({phase_name, " result"}, expected.result, rsp.result);
      check_value({phase_name, " status"}, 32'(expected.status), 32'(rsp.status));
      if (fixed_latency) begin
        check_value({phase_name, " latency"}, 32'(simd_op_pkg::NUM_PIPE_REGS),
                    32'(cycle - acc_cycle));
      end
    end
  endtask

  always @(posedge clk) begin
    cycle++;
    if (cycle > TIMEOUT_CYCLES) begin
      $display("Simulation FAILED");
      $fatal(1, "Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end else if (rst_n) begin
      took_req = in_valid && in_ready;
      if (out_valid && out_ready) check_response();
      if (took_req) begin
        exp_q.push_back(ref_response(req));
        acc_q.push_back(cycle);
      end
    end
  end

  initial begin
    seed          = 55;
    cycle         = 0;
    took_req      = 1'b0;
    fixed_latency = 1'b0;
    next_tag      = 4'd0;
    phase_name    = "reset";
    req           = '0;
    in_valid      = 1'b0;
    out_ready     = 1'b0;
    @(posedge rst_n);
    @(negedge clk);
    check_value("reset out_valid", 32'h0, 32'(out_valid));
    check_value("reset busy", 32'h0, 32'(busy));
    check_value("reset in_ready", 32'h1, 32'(in_ready));
    run_phase("fp32", 0, 100, 0, 1'b1);
    run_phase("fp16_vector", 1, 100, 0, 1'b1);
    run_phase("fp16_scalar", 2, 100, 30, 1'b1);
    run_phase("mixed", 3, 200, 50, 1'b0);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- files.f
+incdir+.
fp_fmt_pkg.sv
simd_op_pkg.sv
fp_lane_op.sv
lane_pipe.sv
result_pack.sv
simd_slice_top.sv
tb_clk_gen.sv
simd_slice_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the slice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f \
  --top-module simd_slice_tb -o simd_slice_sim

./obj_dir/simd_slice_sim
